//--- Bender.yml
package:
  name: ex_stage

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ex_pkg.sv
      - hdl/phys_regfile.sv
      - hdl/operand_select.sv
      - hdl/int_unit.sv
      - hdl/pipe_mult.sv
      - hdl/completion_queue.sv
      - hdl/ex_stage.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/ex_stage_tb.sv

//--- bench/ex_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_consts.svh"

module ex_stage_tb;

	localparam int MAX_RECS = 128;
	localparam int NFIELDS  = 14;
	localparam int NUM_TAGS = 1 << `ROB_IDX_WIDTH;

	logic                       clock;
	logic                       reset;
	logic                       wb_en;
	logic [`PREG_IDX_WIDTH-1:0] wb_idx;
	logic [`XLEN-1:0]           wb_data;
	logic                       is_valid;
	logic [31:0]                is_inst;
	logic [`XLEN-1:0]           is_pc;
	logic [`XLEN-1:0]           is_npc;
	logic [`PREG_IDX_WIDTH-1:0] is_prega_idx;
	logic [`PREG_IDX_WIDTH-1:0] is_pregb_idx;
	logic [`PREG_IDX_WIDTH-1:0] is_pdest_idx;
	logic [`ROB_IDX_WIDTH-1:0]  is_rob_idx;
	ex_pkg::opa_sel_t           is_opa_select;
	ex_pkg::opb_sel_t           is_opb_select;
	ex_pkg::alu_func_t          is_alu_func;
	logic                       is_cond_branch;
	logic                       is_uncond_branch;
	logic                       is_credit;
	logic                       cm_valid;
	logic [`ROB_IDX_WIDTH-1:0]  cm_rob_idx;
	logic [`PREG_IDX_WIDTH-1:0] cm_pdest_idx;
	logic [`XLEN-1:0]           cm_result;
	logic                       cm_take_branch;
	logic                       cm_credit;

	// Records from the data file with fields flattened per record
	logic [63:0] rec_kind [MAX_RECS];
	logic [31:0] rec_f    [MAX_RECS*NFIELDS];
	int          num_recs = 0;
	logic        loaded = 1'b0;

	// Scoreboard indexed by ROB tag
	logic                       exp_live   [NUM_TAGS];
	logic [`XLEN-1:0]           exp_result [NUM_TAGS];
	logic                       exp_br     [NUM_TAGS];
	logic [`PREG_IDX_WIDTH-1:0] exp_pdest  [NUM_TAGS];
	int                         outstanding = 0;

	int     cycle = 0;
	int     issue_credits = `CQ_DEPTH;
	int     transfers = 0;
	int     returned = 0;
	int     credit_pulses = 0;
	int     stall_end = 0;
	int     last_due = 0;
	int     due_q [$];
	integer seed;
	int     value_errors = 0;
	int     other_errors = 0;

	ex_stage DUT (
		.clock            (clock),
		.reset            (reset),
		.wb_en            (wb_en),
		.wb_idx           (wb_idx),
		.wb_data          (wb_data),
		.is_valid         (is_valid),
		.is_inst          (is_inst),
		.is_pc            (is_pc),
		.is_npc           (is_npc),
		.is_prega_idx     (is_prega_idx),
		.is_pregb_idx     (is_pregb_idx),
		.is_pdest_idx     (is_pdest_idx),
		.is_rob_idx       (is_rob_idx),
		.is_opa_select    (is_opa_select),
		.is_opb_select    (is_opb_select),
		.is_alu_func      (is_alu_func),
		.is_cond_branch   (is_cond_branch),
		.is_uncond_branch (is_uncond_branch),
		.is_credit        (is_credit),
		.cm_valid         (cm_valid),
		.cm_rob_idx       (cm_rob_idx),
		.cm_pdest_idx     (cm_pdest_idx),
		.cm_result        (cm_result),
		.cm_take_branch   (cm_take_branch),
		.cm_credit        (cm_credit)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	initial begin
		forever begin
			@(posedge clock);
			cycle++;
		end
	end

	//////////////////////////////////////////////////
	// File loading and issue driving

	task automatic load_tests();
		int               fd;
		int               n;
		int               b;
		logic [8*256-1:0] line;
		logic [63:0]      word;
		fd = $fopen("bench/ex_tests.txt", "r");
		if (fd == 0) begin
			other_errors++;
			$display("Could not open bench/ex_tests.txt");
			return;
		end
		while (!$feof(fd) && num_recs < MAX_RECS) begin
			line = '0;
			n = $fgets(line, fd);
			if (n > 0 && $sscanf(line, "%s", word) == 1 && word != "#") begin
				b = num_recs * NFIELDS;
				if (word == "W")
					n = $sscanf(line, "%s %h %h", word, rec_f[b], rec_f[b+1]) - 3;
				else if (word == "S")
					n = $sscanf(line, "%s %d", word, rec_f[b]) - 2;
				else if (word == "I")
					n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						word, rec_f[b], rec_f[b+1], rec_f[b+2], rec_f[b+3],
						rec_f[b+4], rec_f[b+5], rec_f[b+6], rec_f[b+7],
						rec_f[b+8], rec_f[b+9], rec_f[b+10], rec_f[b+11],
						rec_f[b+12], rec_f[b+13]) - 15;
				else
					n = -1;
				assert (n == 0) else begin
					other_errors++;
					$display("Malformed record %0d in the test file", num_recs);
				end
				rec_kind[num_recs] = word;
				num_recs++;
			end
		end
		$fclose(fd);
	endtask

	task automatic drive_idle();
		wb_en            = 1'b0;
		wb_idx           = '0;
		wb_data          = '0;
		is_valid         = 1'b0;
		is_inst          = '0;
		is_pc            = '0;
		is_npc           = '0;
		is_prega_idx     = '0;
		is_pregb_idx     = '0;
		is_pdest_idx     = '0;
		is_rob_idx       = '0;
		is_opa_select    = ex_pkg::OPA_IS_RS1;
		is_opb_select    = ex_pkg::OPB_IS_RS2;
		is_alu_func      = ex_pkg::ALU_ADD;
		is_cond_branch   = 1'b0;
		is_uncond_branch = 1'b0;
	endtask

	task automatic next_cycle();
		@(posedge clock);
		#1;
		drive_idle();
	endtask

	task automatic issue_record(input int b);
		int tag;
		tag = int'(rec_f[b][`ROB_IDX_WIDTH-1:0]);
		is_valid         = 1'b1;
		is_rob_idx       = rec_f[b][`ROB_IDX_WIDTH-1:0];
		is_pdest_idx     = rec_f[b+1][`PREG_IDX_WIDTH-1:0];
		is_prega_idx     = rec_f[b+2][`PREG_IDX_WIDTH-1:0];
		is_pregb_idx     = rec_f[b+3][`PREG_IDX_WIDTH-1:0];
		is_opa_select    = ex_pkg::opa_sel_t'(rec_f[b+4][1:0]);
		is_opb_select    = ex_pkg::opb_sel_t'(rec_f[b+5][2:0]);
		is_alu_func      = ex_pkg::alu_func_t'(rec_f[b+6][3:0]);
		is_cond_branch   = rec_f[b+7][0];
		is_uncond_branch = rec_f[b+8][0];
		is_inst          = rec_f[b+9];
		is_pc            = rec_f[b+10];
		is_npc           = rec_f[b+11];
		issue_credits--;  // One queue slot spent
		assert (!exp_live[tag]) else begin
			other_errors++;
			$display("ROB tag 0x%h issued again while still in flight", is_rob_idx);
		end
		exp_live[tag]   = 1'b1;
		exp_result[tag] = rec_f[b+12];
		exp_br[tag]     = rec_f[b+13][0];
		exp_pdest[tag]  = rec_f[b+1][`PREG_IDX_WIDTH-1:0];
		outstanding++;
	endtask

	task automatic run_record(input int r);
		int b;
		b = r * NFIELDS;
		if (rec_kind[r] == "W") begin
			next_cycle();
			wb_en   = 1'b1;
			wb_idx  = rec_f[b][`PREG_IDX_WIDTH-1:0];
			wb_data = rec_f[b+1];
		end else if (rec_kind[r] == "S") begin
			stall_end = cycle + int'(rec_f[b]);  // Issue keeps going meanwhile
		end else if (rec_kind[r] == "I") begin
			next_cycle();
			while (issue_credits == 0)
				next_cycle();
			issue_record(b);
		end
	endtask

	//////////////////////////////////////////////////
	// Commit model and scoreboard

	initial begin
		cm_credit = 1'b0;
		forever begin
			@(posedge clock);
			#1;
			cm_credit = 1'b0;
			if (cycle >= stall_end && due_q.size() > 0 && due_q[0] <= cycle) begin
				cm_credit = 1'b1;
				void'(due_q.pop_front());
			end
		end
	end

	task automatic check_value(input string name, input logic [`ROB_IDX_WIDTH-1:0] tag,
			input logic [31:0] got, input logic [31:0] expected);
		assert (got === expected) else begin
			value_errors++;
			$display("[ERROR] %s for ROB tag 0x%h: got 0x%h, expected 0x%h",
				name, tag, got, expected);
		end
	endtask

	task automatic check_completion();
		int tag;
		tag = int'(cm_rob_idx);
		assert (exp_live[tag] === 1'b1) else begin
			other_errors++;
			$display("Completion for ROB tag 0x%h that is not in flight", cm_rob_idx);
		end
		if (exp_live[tag] === 1'b1) begin
			check_value("cm_result", cm_rob_idx, cm_result, exp_result[tag]);
			check_value("cm_take_branch", cm_rob_idx, 32'(cm_take_branch), 32'(exp_br[tag]));
			check_value("cm_pdest_idx", cm_rob_idx, 32'(cm_pdest_idx), 32'(exp_pdest[tag]));
			exp_live[tag] = 1'b0;
			outstanding--;
		end
	endtask

	// Sampled mid-cycle after the outputs settle
	task automatic check_cycle();
		int due;
		assert (is_credit === cm_valid) else begin
			value_errors++;
			$display("[ERROR] is_credit: got 0x%h, expected 0x%h", is_credit, cm_valid);
		end
		if (cm_valid === 1'b1) begin
			assert (transfers < `CM_CREDITS + returned) else begin
				other_errors++;
				$display("Completion transfer in cycle %0d without a commit credit", cycle);
			end
			transfers++;
			check_completion();
			due = cycle + 1 + int'($unsigned($random(seed)) % 3);
			if (due <= last_due)
				due = last_due + 1;  // One return per cycle
			last_due = due;
			due_q.push_back(due);
		end
		if (is_credit === 1'b1) begin
			credit_pulses++;
			issue_credits++;
			assert (issue_credits <= `CQ_DEPTH) else begin
				other_errors++;
				$display("Issue credits returned beyond the queue depth");
			end
		end
		if (cm_credit)
			returned++;
		assert (credit_pulses == transfers) else begin
			other_errors++;
			$display("Issue credit pulses do not match completion transfers");
		end
	endtask

	initial begin
		forever begin
			@(negedge clock);
			if (!reset)
				check_cycle();
		end
	end

	// Watchdog sized from the record count
	initial begin
		wait (loaded);
		repeat (num_recs * 50 + 20) @(posedge clock);
		$display("Watchdog expired with %0d instructions still in flight", outstanding);
		$display("Errors: %0d value, %0d other", value_errors, other_errors);
		$display("test failed");
		$finish;
	end

	//////////////////////////////////////////////////
	// Main sequence

	initial begin
		seed  = 32'hce6f_1732;
		reset = 1'b1;
		drive_idle();
		for (int t = 0; t < NUM_TAGS; t++)
			exp_live[t] = 1'b0;
		load_tests();
		loaded = 1'b1;
		repeat (4) @(posedge clock);
		#1;
		reset = 1'b0;
		@(negedge clock);
		assert (cm_valid === 1'b0 && is_credit === 1'b0) else begin
			value_errors++;
			$display("[ERROR] cm_valid 0x%h is_credit 0x%h after reset, expected 0x0",
				cm_valid, is_credit);
		end
		for (int r = 0; r < num_recs; r++)
			run_record(r);
		next_cycle();
		while (outstanding != 0)
			@(posedge clock);
		while (due_q.size() != 0)
			@(posedge clock);
		repeat (4) @(posedge clock);
		assert (issue_credits == `CQ_DEPTH) else begin
			value_errors++;
			$display("[ERROR] issue_credits: got 0x%h, expected 0x%h",
				issue_credits, `CQ_DEPTH);
		end
		$display("Errors: %0d value, %0d other", value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/ex_tests.txt
# W preg data, S stall_cycles (decimal), all other fields hex
# I rob pdest prega pregb opa_sel opb_sel func cond uncond inst pc npc exp_result exp_take
W 01 00000007
W 02 fffffff9
W 03 80000000
W 04 00000003
W 05 12345678
W 06 00000007
I 01 21 01 05 0 0 0 0 0 00000000 00001000 00001004 1234567f 0
I 02 22 01 02 0 0 1 0 0 00000000 00001000 00001004 0000000e 0
I 03 23 03 04 0 0 9 0 0 00000000 00001000 00001004 f0000000 0
I 13 33 02 01 0 0 a 0 0 00000000 00001000 00001004 ffffffcf 0
I 04 24 03 04 0 0 8 0 0 00000000 00001000 00001004 10000000 0
I 14 34 02 01 0 0 b 0 0 00000000 00001000 00001004 ffffffff 0
I 15 35 01 02 0 0 c 0 0 00000000 00001000 00001004 00000006 0
I 05 25 02 01 0 0 5 0 0 00000000 00001000 00001004 00000001 0
I 16 36 02 02 0 0 d 0 0 00000000 00001000 00001004 fffffff2 0
I 06 26 02 01 0 0 6 0 0 00000000 00001000 00001004 00000000 0
I 07 27 05 02 0 0 4 0 0 00000000 00001000 00001004 edcba981 0
I 08 28 01 00 0 1 0 0 0 fff00000 00001000 00001004 00000006 0
I 09 29 04 00 0 1 7 0 0 00400000 00001000 00001004 00000030 0
I 0a 2a 00 00 3 4 0 0 0 abcde000 00001000 00001004 abcde000 0
I 0b 2b 05 00 0 2 2 0 0 00000f80 00001000 00001004 00000018 0
I 17 37 05 04 0 0 a 0 0 00000000 00001000 00001004 369d0368 0
I 0c 2c 01 06 2 3 0 1 0 00000800 00001000 00001004 00001010 1
I 18 38 03 03 0 0 b 0 0 00000000 00001000 00001004 40000000 0
I 0d 2d 01 06 2 3 0 1 0 00001800 00001000 00001004 00001010 0
I 0e 2e 02 01 2 3 0 1 0 00004800 00001000 00001004 00001010 1
I 19 39 03 04 0 0 d 0 0 00000000 00001000 00001004 00000001 0
I 0f 2f 02 01 2 3 0 1 0 00005800 00001000 00001004 00001010 0
I 10 30 02 01 2 3 0 1 0 00006800 00001000 00001004 00001010 0
I 11 31 02 01 2 3 0 1 0 00007800 00001000 00001004 00001010 1
I 12 32 00 00 2 5 0 0 1 00800000 00001000 00001004 00001008 1
S 20
I 1a 3a 04 01 0 0 0 0 0 00000000 00001000 00001004 0000000a 0
I 1b 3b 04 01 0 0 a 0 0 00000000 00001000 00001004 00000015 0
I 1c 3c 04 01 0 0 1 0 0 00000000 00001000 00001004 fffffffc 0
I 1d 3d 02 04 0 0 9 0 0 00000000 00001000 00001004 ffffffff 0
I 1e 3e 01 02 0 0 6 0 0 00000000 00001000 00001004 00000001 0
I 1f 3f 03 01 0 0 5 0 0 00000000 00001000 00001004 00000001 0

//--- compile.f
+incdir+hdl
hdl/ex_pkg.sv
hdl/phys_regfile.sv
hdl/operand_select.sv
hdl/int_unit.sv
hdl/pipe_mult.sv
hdl/completion_queue.sv
hdl/ex_stage.sv
bench/ex_stage_tb.sv

//--- hdl/completion_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_consts.svh"

module completion_queue (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       mult_wr,
	input  logic [`ROB_IDX_WIDTH-1:0]  mult_rob,
	input  logic [`PREG_IDX_WIDTH-1:0] mult_pdest,
	input  logic [`XLEN-1:0]           mult_result,
	input  logic                       alu_wr,
	input  logic [`ROB_IDX_WIDTH-1:0]  alu_rob,
	input  logic [`PREG_IDX_WIDTH-1:0] alu_pdest,
	input  logic [`XLEN-1:0]           alu_result,
	input  logic                       alu_take_branch,
	input  logic                       cm_credit,
	output logic                       cm_valid,
	output logic [`ROB_IDX_WIDTH-1:0]  cm_rob_idx,
	output logic [`PREG_IDX_WIDTH-1:0] cm_pdest_idx,
	output logic [`XLEN-1:0]           cm_result,
	output logic                       cm_take_branch,
	output logic                       is_credit
);

	// Pointers wrap naturally on a power-of-two depth
	localparam int PTR_W = $clog2(`CQ_DEPTH);
	localparam int CNT_W = $clog2(`CQ_DEPTH + 1);
	localparam int CRD_W = $clog2(`CM_CREDITS + 1);

	logic [`ROB_IDX_WIDTH-1:0]  rob_q    [`CQ_DEPTH];
	logic [`PREG_IDX_WIDTH-1:0] pdest_q  [`CQ_DEPTH];
	logic [`XLEN-1:0]           result_q [`CQ_DEPTH];
	logic                       br_q     [`CQ_DEPTH];

	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] tail;
	logic [PTR_W-1:0] alu_slot;
	logic [CNT_W-1:0] count;
	logic [CRD_W-1:0] cm_cnt;
	logic             pop;

	//////////////////////////////////////////////////
	// Enqueue with the multiplier entry first
	assign alu_slot = mult_wr ? tail + PTR_W'(1) : tail;

	always_ff @(posedge clock) begin
		if (mult_wr) begin
			rob_q[tail]    <= mult_rob;
			pdest_q[tail]  <= mult_pdest;
			result_q[tail] <= mult_result;
			br_q[tail]     <= 1'b0;  // Multiplies never branch
		end
		if (alu_wr) begin
			rob_q[alu_slot]    <= alu_rob;
			pdest_q[alu_slot]  <= alu_pdest;
			result_q[alu_slot] <= alu_result;
			br_q[alu_slot]     <= alu_take_branch;
		end
	end

	//////////////////////////////////////////////////
	// Dequeue onto the completion bus
	assign cm_valid       = (count != '0) && (cm_cnt != '0);
	assign pop            = cm_valid;
	assign is_credit      = pop;  // Slot handed back to the issuer
	assign cm_rob_idx     = rob_q[head];
	assign cm_pdest_idx   = pdest_q[head];
	assign cm_result      = result_q[head];
	assign cm_take_branch = br_q[head];

	always_ff @(posedge clock) begin
		if (reset) begin
			head   <= '0;
			tail   <= '0;
			count  <= '0;
			cm_cnt <= CRD_W'(`CM_CREDITS);
		end else begin
			head   <= head + PTR_W'(pop);
			tail   <= tail + PTR_W'(mult_wr) + PTR_W'(alu_wr);
			count  <= count + CNT_W'(mult_wr) + CNT_W'(alu_wr) - CNT_W'(pop);
			cm_cnt <= cm_cnt + CRD_W'(cm_credit) - CRD_W'(pop);
		end
	end

	// Issue credits must keep the writes within the free slots
	a_no_overflow: assert property (@(posedge clock) disable iff (reset)
		(CNT_W'(mult_wr) + CNT_W'(alu_wr)) <= (CNT_W'(`CQ_DEPTH) - count))
		else $error("completion queue overflow");

	// Commit side returns no more than it was granted
	a_credit_bound: assert property (@(posedge clock) disable iff (reset)
		cm_cnt <= CRD_W'(`CM_CREDITS))
		else $error("commit credit count above grant");

endmodule

`default_nettype wire

//--- hdl/ex_consts.svh
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// Datapath and index widths
`define XLEN            32
`define PREG_IDX_WIDTH  6
`define NUM_PREGS       64
`define ROB_IDX_WIDTH   5

// Completion queue depth, also the issuer's starting credits
`define CQ_DEPTH        4

// Credits the commit side grants out of reset
`define CM_CREDITS      2

// Multiplier latency in cycles
`define MULT_STAGES     4

// Values seen on an invalid select or an unqueued function
`define OPA_POISON      32'hdeadfbac
`define OPB_POISON      32'hfacefeed
`define ALU_POISON      32'hfacebeec

`endif

//--- hdl/ex_pkg.sv
`default_nettype none

package ex_pkg;

	// ALU and multiplier functions
	typedef enum logic [3:0] {
		ALU_ADD    = 4'h0,
		ALU_SUB    = 4'h1,
		ALU_AND    = 4'h2,
		ALU_OR     = 4'h3,
		ALU_XOR    = 4'h4,
		ALU_SLT    = 4'h5,
		ALU_SLTU   = 4'h6,
		ALU_SLL    = 4'h7,
		ALU_SRL    = 4'h8,
		ALU_SRA    = 4'h9,
		ALU_MUL    = 4'ha,
		ALU_MULH   = 4'hb,
		ALU_MULHSU = 4'hc,
		ALU_MULHU  = 4'hd
	} alu_func_t;

	typedef enum logic [1:0] {
		OPA_IS_RS1  = 2'h0,
		OPA_IS_NPC  = 2'h1,
		OPA_IS_PC   = 2'h2,
		OPA_IS_ZERO = 2'h3
	} opa_sel_t;

	typedef enum logic [2:0] {
		OPB_IS_RS2   = 3'h0,
		OPB_IS_I_IMM = 3'h1,
		OPB_IS_S_IMM = 3'h2,
		OPB_IS_B_IMM = 3'h3,
		OPB_IS_U_IMM = 3'h4,
		OPB_IS_J_IMM = 3'h5
	} opb_sel_t;

	// Encoded as the branch funct3 field
	typedef enum logic [2:0] {
		BR_BEQ  = 3'b000,
		BR_BNE  = 3'b001,
		BR_BLT  = 3'b100,
		BR_BGE  = 3'b101,
		BR_BLTU = 3'b110,
		BR_BGEU = 3'b111
	} br_cond_t;

endpackage

`default_nettype wire

//--- hdl/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_consts.svh"

module ex_stage (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       wb_en,
	input  logic [`PREG_IDX_WIDTH-1:0] wb_idx,
	input  logic [`XLEN-1:0]           wb_data,
	input  logic                       is_valid,
	input  logic [31:0]                is_inst,
	input  logic [`XLEN-1:0]           is_pc,
	input  logic [`XLEN-1:0]           is_npc,
	input  logic [`PREG_IDX_WIDTH-1:0] is_prega_idx,
	input  logic [`PREG_IDX_WIDTH-1:0] is_pregb_idx,
	input  logic [`PREG_IDX_WIDTH-1:0] is_pdest_idx,
	input  logic [`ROB_IDX_WIDTH-1:0]  is_rob_idx,
	input  ex_pkg::opa_sel_t           is_opa_select,
	input  ex_pkg::opb_sel_t           is_opb_select,
	input  ex_pkg::alu_func_t          is_alu_func,
	input  logic                       is_cond_branch,
	input  logic                       is_uncond_branch,
	output logic                       is_credit,
	output logic                       cm_valid,
	output logic [`ROB_IDX_WIDTH-1:0]  cm_rob_idx,
	output logic [`PREG_IDX_WIDTH-1:0] cm_pdest_idx,
	output logic [`XLEN-1:0]           cm_result,
	output logic                       cm_take_branch,
	input  logic                       cm_credit
);

	logic [`XLEN-1:0]           rega_value;
	logic [`XLEN-1:0]           regb_value;
	logic [`XLEN-1:0]           opa;
	logic [`XLEN-1:0]           opb;
	logic [`XLEN-1:0]           alu_result;
	logic                       take_branch;
	logic                       is_mult;
	logic                       mult_start;
	logic                       alu_wr;
	logic                       mult_done;
	logic [`XLEN-1:0]           mult_product;
	logic [`ROB_IDX_WIDTH-1:0]  mult_rob;
	logic [`PREG_IDX_WIDTH-1:0] mult_pdest;

	//////////////////////////////////////////////////
	// Issue steering
	assign is_mult = is_alu_func inside {ex_pkg::ALU_MUL, ex_pkg::ALU_MULH,
	                                     ex_pkg::ALU_MULHSU, ex_pkg::ALU_MULHU};
	assign mult_start = is_valid & is_mult;
	assign alu_wr     = is_valid & ~is_mult;  // Branches included

	phys_regfile regfile_0 (
		.clock   (clock),
		.rda_idx (is_prega_idx),
		.rdb_idx (is_pregb_idx),
		.rda_out (rega_value),
		.rdb_out (regb_value),
		.wr_en   (wb_en),
		.wr_idx  (wb_idx),
		.wr_data (wb_data)
	);

	operand_select opsel_0 (
		.inst       (is_inst),
		.pc         (is_pc),
		.npc        (is_npc),
		.rs1_value  (rega_value),
		.rs2_value  (regb_value),
		.opa_select (is_opa_select),
		.opb_select (is_opb_select),
		.opa        (opa),
		.opb        (opb)
	);

	int_unit int_0 (
		.opa           (opa),
		.opb           (opb),
		.rs1_value     (rega_value),
		.rs2_value     (regb_value),
		.func          (is_alu_func),
		.inst_funct3   (ex_pkg::br_cond_t'(is_inst[14:12])),
		.cond_branch   (is_cond_branch),
		.uncond_branch (is_uncond_branch),
		.result        (alu_result),
		.take_branch   (take_branch)
	);

	pipe_mult mult_0 (
		.clock       (clock),
		.reset       (reset),
		.start       (mult_start),
		.func        (is_alu_func),
		.mcand       (opa),
		.mplier      (opb),
		.rob_idx_in  (is_rob_idx),
		.pdest_in    (is_pdest_idx),
		.done        (mult_done),
		.product     (mult_product),
		.rob_idx_out (mult_rob),
		.pdest_out   (mult_pdest)
	);

	//////////////////////////////////////////////////
	// Results merge onto the completion bus
	completion_queue cq_0 (
		.clock           (clock),
		.reset           (reset),
		.mult_wr         (mult_done),
		.mult_rob        (mult_rob),
		.mult_pdest      (mult_pdest),
		.mult_result     (mult_product),
		.alu_wr          (alu_wr),
		.alu_rob         (is_rob_idx),
		.alu_pdest       (is_pdest_idx),
		.alu_result      (alu_result),
		.alu_take_branch (take_branch),
		.cm_credit       (cm_credit),
		.cm_valid        (cm_valid),
		.cm_rob_idx      (cm_rob_idx),
		.cm_pdest_idx    (cm_pdest_idx),
		.cm_result       (cm_result),
		.cm_take_branch  (cm_take_branch),
		.is_credit       (is_credit)
	);

endmodule

`default_nettype wire

//--- hdl/int_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_consts.svh"

module int_unit (
	input  logic [`XLEN-1:0]  opa,
	input  logic [`XLEN-1:0]  opb,
	input  logic [`XLEN-1:0]  rs1_value,
	input  logic [`XLEN-1:0]  rs2_value,
	input  ex_pkg::alu_func_t func,
	input  ex_pkg::br_cond_t  inst_funct3,
	input  logic              cond_branch,
	input  logic              uncond_branch,
	output logic [`XLEN-1:0]  result,
	output logic              take_branch
);

	logic signed [`XLEN-1:0] signed_opa;
	logic signed [`XLEN-1:0] signed_opb;
	logic signed [`XLEN-1:0] signed_rs1;
	logic signed [`XLEN-1:0] signed_rs2;
	logic                    br_true;

	assign signed_opa = opa;
	assign signed_opb = opb;
	assign signed_rs1 = rs1_value;
	assign signed_rs2 = rs2_value;

	always_comb begin
		case (func)
			ex_pkg::ALU_ADD:  result = opa + opb;
			ex_pkg::ALU_SUB:  result = opa - opb;
			ex_pkg::ALU_AND:  result = opa & opb;
			ex_pkg::ALU_OR:   result = opa | opb;
			ex_pkg::ALU_XOR:  result = opa ^ opb;
			ex_pkg::ALU_SLT:  result = {{(`XLEN-1){1'b0}}, signed_opa < signed_opb};
			ex_pkg::ALU_SLTU: result = {{(`XLEN-1){1'b0}}, opa < opb};
			ex_pkg::ALU_SLL:  result = opa << opb[4:0];
			ex_pkg::ALU_SRL:  result = opa >> opb[4:0];
			ex_pkg::ALU_SRA:  result = signed_opa >>> opb[4:0];
			default:          result = `ALU_POISON;  // Multiplies go to pipe_mult
		endcase
	end

	//////////////////////////////////////////////////
	// Branch condition on the register values
	always_comb begin
		case (inst_funct3)
			ex_pkg::BR_BEQ:  br_true = rs1_value == rs2_value;
			ex_pkg::BR_BNE:  br_true = rs1_value != rs2_value;
			ex_pkg::BR_BLT:  br_true = signed_rs1 < signed_rs2;
			ex_pkg::BR_BGE:  br_true = signed_rs1 >= signed_rs2;
			ex_pkg::BR_BLTU: br_true = rs1_value < rs2_value;
			ex_pkg::BR_BGEU: br_true = rs1_value >= rs2_value;
			default:         br_true = 1'b0;
		endcase
	end

	assign take_branch = uncond_branch | (cond_branch & br_true);

endmodule

`default_nettype wire

//--- hdl/operand_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_consts.svh"

module operand_select (
	input  logic [31:0]         inst,
	input  logic [`XLEN-1:0]    pc,
	input  logic [`XLEN-1:0]    npc,
	input  logic [`XLEN-1:0]    rs1_value,
	input  logic [`XLEN-1:0]    rs2_value,
	input  ex_pkg::opa_sel_t    opa_select,
	input  ex_pkg::opb_sel_t    opb_select,
	output logic [`XLEN-1:0]    opa,
	output logic [`XLEN-1:0]    opb
);

	logic [`XLEN-1:0] i_imm;
	logic [`XLEN-1:0] s_imm;
	logic [`XLEN-1:0] b_imm;
	logic [`XLEN-1:0] u_imm;
	logic [`XLEN-1:0] j_imm;

	// Sign-extended immediates
	assign i_imm = {{20{inst[31]}}, inst[31:20]};
	assign s_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign b_imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign u_imm = {inst[31:12], 12'b0};
	assign j_imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		opa = `OPA_POISON;
		case (opa_select)
			ex_pkg::OPA_IS_RS1:  opa = rs1_value;
			ex_pkg::OPA_IS_NPC:  opa = npc;
			ex_pkg::OPA_IS_PC:   opa = pc;
			ex_pkg::OPA_IS_ZERO: opa = '0;
			default:             opa = `OPA_POISON;
		endcase
	end

	always_comb begin
		opb = `OPB_POISON;  // Two encodings left unused
		case (opb_select)
			ex_pkg::OPB_IS_RS2:   opb = rs2_value;
			ex_pkg::OPB_IS_I_IMM: opb = i_imm;
			ex_pkg::OPB_IS_S_IMM: opb = s_imm;
			ex_pkg::OPB_IS_B_IMM: opb = b_imm;
			ex_pkg::OPB_IS_U_IMM: opb = u_imm;
			ex_pkg::OPB_IS_J_IMM: opb = j_imm;
			default:              opb = `OPB_POISON;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/phys_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_consts.svh"

module phys_regfile (
	input  logic                       clock,
	input  logic [`PREG_IDX_WIDTH-1:0] rda_idx,
	input  logic [`PREG_IDX_WIDTH-1:0] rdb_idx,
	output logic [`XLEN-1:0]           rda_out,
	output logic [`XLEN-1:0]           rdb_out,
	input  logic                       wr_en,
	input  logic [`PREG_IDX_WIDTH-1:0] wr_idx,
	input  logic [`XLEN-1:0]           wr_data
);

	logic [`XLEN-1:0] registers [`NUM_PREGS];

	// Reads are combinational, old value during a same-cycle write
	always_comb begin
		rda_out = registers[rda_idx];
		if (rda_idx == '0)
			rda_out = '0;  // Zero register
		rdb_out = registers[rdb_idx];
		if (rdb_idx == '0)
			rdb_out = '0;
	end

	always_ff @(posedge clock) begin
		if (wr_en && (wr_idx != '0))
			registers[wr_idx] <= wr_data;
	end

endmodule

`default_nettype wire

//--- hdl/pipe_mult.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_consts.svh"

module pipe_mult (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       start,
	input  ex_pkg::alu_func_t          func,
	input  logic [`XLEN-1:0]           mcand,
	input  logic [`XLEN-1:0]           mplier,
	input  logic [`ROB_IDX_WIDTH-1:0]  rob_idx_in,
	input  logic [`PREG_IDX_WIDTH-1:0] pdest_in,
	output logic                       done,
	output logic [`XLEN-1:0]           product,
	output logic [`ROB_IDX_WIDTH-1:0]  rob_idx_out,
	output logic [`PREG_IDX_WIDTH-1:0] pdest_out
);

	localparam int N = `MULT_STAGES;

	logic                       mcand_signed;
	logic                       mplier_signed;
	logic [2*`XLEN-1:0]         mcand_ext;
	logic [2*`XLEN-1:0]         mplier_ext;
	logic [2*`XLEN-1:0]         product_full;
	logic [N-1:0]               stage_valid;
	logic [N-1:0]               stage_high;
	logic [2*`XLEN-1:0]         stage_prod  [N];
	logic [`ROB_IDX_WIDTH-1:0]  stage_rob   [N];
	logic [`PREG_IDX_WIDTH-1:0] stage_pdest [N];

	// MULHSU treats only the multiplicand as signed
	assign mcand_signed  = func inside {ex_pkg::ALU_MUL, ex_pkg::ALU_MULH, ex_pkg::ALU_MULHSU};
	assign mplier_signed = func inside {ex_pkg::ALU_MUL, ex_pkg::ALU_MULH};

	assign mcand_ext  = {{`XLEN{mcand_signed & mcand[`XLEN-1]}}, mcand};
	assign mplier_ext = {{`XLEN{mplier_signed & mplier[`XLEN-1]}}, mplier};
	assign product_full = mcand_ext * mplier_ext;  // Low 64 bits are exact

	always_ff @(posedge clock) begin
		if (reset)
			stage_valid <= '0;
		else
			stage_valid <= {stage_valid[N-2:0], start};
	end

	// Product, half select and tags shift alongside the valid bits
	always_ff @(posedge clock) begin
		stage_prod[0]  <= product_full;
		stage_high[0]  <= (func != ex_pkg::ALU_MUL);
		stage_rob[0]   <= rob_idx_in;
		stage_pdest[0] <= pdest_in;
		for (int i = 1; i < N; i++) begin
			stage_prod[i]  <= stage_prod[i-1];
			stage_high[i]  <= stage_high[i-1];
			stage_rob[i]   <= stage_rob[i-1];
			stage_pdest[i] <= stage_pdest[i-1];
		end
	end

	assign done        = stage_valid[N-1];
	assign rob_idx_out = stage_rob[N-1];
	assign pdest_out   = stage_pdest[N-1];
	assign product     = stage_high[N-1] ? stage_prod[N-1][2*`XLEN-1:`XLEN]
	                                     : stage_prod[N-1][`XLEN-1:0];

	a_done_known: assert property (@(posedge clock) disable iff (reset)
		!$isunknown(done))
		else $error("pipe_mult done is unknown");

endmodule

`default_nettype wire
